/* eeprom_config.svh */
`ifndef EEPROM_CONFIG_SVH
`define EEPROM_CONFIG_SVH

// Storage size in bytes
`define EEPROM_DEPTH 2048

// Storage address width, block bits above the address byte
`define EEPROM_AW 11

// Upper nibble of the control byte
`define EEPROM_DEV_CODE 4'b1010

// Flops per bus line before edge detection
`define EEPROM_SYNC_STAGES 2

`endif

/* eeprom_pkg.sv */
`default_nettype none

package eeprom_pkg;

    // Protocol engine states
    typedef enum logic [2:0] {
        PS_IDLE   = 3'd0,
        PS_CTRL   = 3'd1,
        PS_ADDR   = 3'd2,
        PS_WDATA  = 3'd3,
        PS_RDATA  = 3'd4,
        PS_IGNORE = 3'd5
    } proto_state_e;

    // Direction from bit 0 of the control byte
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } op_e;

endpackage

`default_nettype wire

/* eeprom_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_config.svh"

// Decoded bus conditions from the line sampler
interface bus_event_if;
    logic scl_rise;
    logic scl_fall;
    logic sda_bit;
    logic start;
    logic stop;

    modport src (output scl_rise, output scl_fall, output sda_bit, output start, output stop);
    modport dst (input scl_rise, input scl_fall, input sda_bit, input start, input stop);
endinterface

// Engine requests to the SDA driver
interface tx_ctrl_if;
    logic       ack_req;
    logic       load;
    logic [7:0] tx_byte;
    logic       active;

    modport ctrl (output ack_req, output load, output tx_byte, input active);
    modport drv (input ack_req, input load, input tx_byte, output active);
endinterface

// Single-port memory access
interface mem_port_if;
    logic [`EEPROM_AW-1:0] addr;
    logic [7:0]            wdata;
    logic                  we;
    logic [7:0]            rdata;

    modport host (output addr, output wdata, output we, input rdata);
    modport mem (input addr, input wdata, input we, output rdata);
endinterface

`default_nettype wire

/* eeprom_line_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_config.svh"

module eeprom_line_sampler (
    input wire        scl,
    input wire        rst_n,
    input wire        i2c_scl,
    input wire        i2c_sda,
    bus_event_if.src  ev
);

    logic [`EEPROM_SYNC_STAGES-1:0] scl_sync;
    logic [`EEPROM_SYNC_STAGES-1:0] sda_sync;
    logic                           scl_s;
    logic                           sda_s;
    logic                           scl_q;
    logic                           sda_q;

    assign scl_s = scl_sync[`EEPROM_SYNC_STAGES-1];
    assign sda_s = sda_sync[`EEPROM_SYNC_STAGES-1];

    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            // Idle bus is high on both lines
            scl_sync    <= '1;
            sda_sync    <= '1;
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;
            ev.scl_rise <= 1'b0;
            ev.scl_fall <= 1'b0;
            ev.sda_bit  <= 1'b1;
            ev.start    <= 1'b0;
            ev.stop     <= 1'b0;
        end
        else
        begin
            scl_sync <= {scl_sync[`EEPROM_SYNC_STAGES-2:0], i2c_scl};
            sda_sync <= {sda_sync[`EEPROM_SYNC_STAGES-2:0], i2c_sda};
            scl_q    <= scl_s;
            sda_q    <= sda_s;

            ev.scl_rise <= scl_s & ~scl_q;
            ev.scl_fall <= ~scl_s & scl_q;
            ev.sda_bit  <= sda_s;

            // SDA moving while SCL stays high
            ev.start <= scl_s & scl_q & sda_q & ~sda_s;
            ev.stop  <= scl_s & scl_q & ~sda_q & sda_s;
        end
    end

endmodule

`default_nettype wire

/* eeprom_protocol_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_config.svh"

module eeprom_protocol_fsm (
    input wire        scl,
    input wire        rst_n,
    bus_event_if.dst  ev,
    tx_ctrl_if.ctrl   tx,
    mem_port_if.host  mem
);

    import eeprom_pkg::*;

    proto_state_e          state;
    logic [3:0]            bit_cnt;
    logic [7:0]            shift_reg;
    logic [7:0]            shift_next;
    logic [`EEPROM_AW-1:0] cur_addr;
    logic                  dev_match;
    logic                  bit_rise;
    logic                  byte_done;
    op_e                   ctrl_op;

    assign shift_next = {shift_reg[6:0], ev.sda_bit};
    assign dev_match  = (shift_next[7:4] == `EEPROM_DEV_CODE);
    assign ctrl_op    = op_e'(shift_next[0]);

    // Only rises inside a transaction addressed to this device
    assign bit_rise  = ev.scl_rise && (state != PS_IDLE) && (state != PS_IGNORE);
    assign byte_done = bit_rise && (bit_cnt == 4'd7);

    assign mem.addr   = cur_addr;
    assign tx.tx_byte = mem.rdata;

    always_ff @(posedge scl)
    begin
        if (bit_rise && (bit_cnt != 4'd8))
        begin
            shift_reg <= shift_next;
        end
        if (byte_done && (state == PS_WDATA))
        begin
            mem.wdata <= shift_next;
        end
    end

    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            state      <= PS_IDLE;
            bit_cnt    <= 4'd0;
            cur_addr   <= '0;
            mem.we     <= 1'b0;
            tx.ack_req <= 1'b0;
            tx.load    <= 1'b0;
        end
        else
        begin
            tx.ack_req <= 1'b0;
            tx.load    <= 1'b0;
            mem.we     <= 1'b0;

            // Advance past a byte once it is in the array
            if (mem.we)
            begin
                cur_addr <= cur_addr + 1'b1;
            end

            if (ev.start)
            begin
                state   <= PS_CTRL;
                bit_cnt <= 4'd0;
            end
            else if (ev.stop)
            begin
                state   <= PS_IDLE;
                bit_cnt <= 4'd0;
            end
            else if (bit_rise)
            begin
                if (bit_cnt == 4'd8)
                begin
                    bit_cnt <= 4'd0;
                    if (state == PS_RDATA)
                    begin
                        // Own ack after the control byte or a master ACK
                        if (tx.active || !ev.sda_bit)
                        begin
                            tx.load <= 1'b1;
                        end
                        else
                        begin
                            state <= PS_IDLE;
                        end
                    end
                end
                else
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'd7)
                    begin
                        case (state)
                            PS_CTRL:
                            begin
                                if (dev_match)
                                begin
                                    tx.ack_req <= 1'b1;
                                    cur_addr[`EEPROM_AW-1:8] <= shift_next[3:1];
                                    state <= (ctrl_op == OP_READ) ? PS_RDATA : PS_ADDR;
                                end
                                else
                                begin
                                    state <= PS_IGNORE;
                                end
                            end
                            PS_ADDR:
                            begin
                                tx.ack_req     <= 1'b1;
                                cur_addr[7:0]  <= shift_next;
                                state          <= PS_WDATA;
                            end
                            PS_WDATA:
                            begin
                                tx.ack_req <= 1'b1;
                                mem.we     <= 1'b1;
                            end
                            PS_RDATA:
                            begin
                                // Fetch the next byte before the ack bit
                                cur_addr <= cur_addr + 1'b1;
                            end
                            default:
                            begin
                                state <= state;
                            end
                        endcase
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* eeprom_storage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_config.svh"

module eeprom_storage (
    input wire       scl,
    mem_port_if.mem  mem
);

    logic [7:0] mem_array [`EEPROM_DEPTH];

    always_ff @(posedge scl)
    begin
        if (mem.we)
        begin
            mem_array[mem.addr] <= mem.wdata;
        end
        // Old data on a same-cycle write
        mem.rdata <= mem_array[mem.addr];
    end

endmodule

`default_nettype wire

/* eeprom_sda_driver.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_sda_driver (
    input wire        scl,
    input wire        rst_n,
    bus_event_if.dst  ev,
    tx_ctrl_if.drv    tx,
    output logic      i2c_sda_oe
);

    logic [7:0] tx_shift;
    logic [2:0] bits_left;
    logic       ack_pend;
    logic       ack_on;
    logic       rd_pend;
    logic       rd_on;

    assign tx.active = ack_on | rd_on;

    always_ff @(posedge scl)
    begin
        if (tx.load)
        begin
            tx_shift <= tx.tx_byte;
        end
        else if (ev.scl_fall && (rd_pend || rd_on))
        begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    always_ff @(posedge scl)
    begin
        if (!rst_n || ev.start || ev.stop)
        begin
            i2c_sda_oe <= 1'b0;
            bits_left  <= 3'd0;
            ack_pend   <= 1'b0;
            ack_on     <= 1'b0;
            rd_pend    <= 1'b0;
            rd_on      <= 1'b0;
        end
        else
        begin
            if (tx.ack_req)
            begin
                ack_pend <= 1'b1;
            end
            if (tx.load)
            begin
                rd_pend <= 1'b1;
            end

            if (ev.scl_fall)
            begin
                if (ack_pend)
                begin
                    i2c_sda_oe <= 1'b1;
                    ack_on     <= 1'b1;
                    ack_pend   <= 1'b0;
                end
                else if (rd_pend)
                begin
                    // Bit 7 replaces any ack still on the line
                    i2c_sda_oe <= ~tx_shift[7];
                    bits_left  <= 3'd7;
                    ack_on     <= 1'b0;
                    rd_on      <= 1'b1;
                    rd_pend    <= 1'b0;
                end
                else if (rd_on)
                begin
                    if (bits_left == 3'd0)
                    begin
                        // Hand the line over for the master ack
                        i2c_sda_oe <= 1'b0;
                        rd_on      <= 1'b0;
                    end
                    else
                    begin
                        i2c_sda_oe <= ~tx_shift[7];
                        bits_left  <= bits_left - 3'd1;
                    end
                end
                else if (ack_on)
                begin
                    i2c_sda_oe <= 1'b0;
                    ack_on     <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* eeprom_top.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_top (
    input wire   scl,
    input wire   rst_n,
    input wire   i2c_scl,
    input wire   i2c_sda,
    output wire  i2c_sda_oe
);

    bus_event_if ev_bus ();
    tx_ctrl_if   tx_bus ();
    mem_port_if  mem_bus ();

    eeprom_line_sampler u_line_sampler (
        .scl     (scl),
        .rst_n   (rst_n),
        .i2c_scl (i2c_scl),
        .i2c_sda (i2c_sda),
        .ev      (ev_bus)
    );

    eeprom_protocol_fsm u_protocol_fsm (
        .scl   (scl),
        .rst_n (rst_n),
        .ev    (ev_bus),
        .tx    (tx_bus),
        .mem   (mem_bus)
    );

    eeprom_storage u_storage (
        .scl (scl),
        .mem (mem_bus)
    );

    // High on the output pulls SDA low
    eeprom_sda_driver u_sda_driver (
        .scl        (scl),
        .rst_n      (rst_n),
        .ev         (ev_bus),
        .tx         (tx_bus),
        .i2c_sda_oe (i2c_sda_oe)
    );

endmodule

`default_nettype wire

/* tb_eeprom_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eeprom_config.svh"

module tb_eeprom_top;

    localparam int LEVEL_TIMEOUT = 64;
    localparam int IDLE_CYCLES   = 5 * 16;

    logic scl;
    logic rst_n;
    logic i2c_scl;
    logic sda_m;
    wire  i2c_sda;
    wire  i2c_sda_oe;

    integer seed = 32'hba27e160;

    logic [7:0]            ref_mem [`EEPROM_DEPTH];
    logic [7:0]            wr_q [$];
    logic [7:0]            rd_q [$];
    logic [`EEPROM_AW-1:0] kept_addr;

    // Master and slave can only pull the line low
    assign i2c_sda = sda_m & ~i2c_sda_oe;

    eeprom_top u_dut (
        .scl        (scl),
        .rst_n      (rst_n),
        .i2c_scl    (i2c_scl),
        .i2c_sda    (i2c_sda),
        .i2c_sda_oe (i2c_sda_oe)
    );

    initial
    begin
        scl = 1'b0;
        forever #10 scl = ~scl;
    end

    function automatic logic [7:0] random_byte();
        integer r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic logic [`EEPROM_AW-1:0] random_addr();
        integer r;
        r = $random(seed);
        return r[`EEPROM_AW-1:0];
    endfunction

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_ack(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t ns: %s, ack got %0b expected %0b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t ns: %s, got %02h expected %02h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_oe(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t ns: %s, sda_oe got %0b expected %0b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic wait_cycles(input int n);
        int i;
        for (i = 0; i < n; i++)
        begin
            @(posedge scl);
        end
    endtask

    task automatic wait_scl_level(input logic level);
        int cnt;
        cnt = 0;
        while ((i2c_scl !== level) && (cnt < LEVEL_TIMEOUT))
        begin
            @(posedge scl);
            cnt++;
        end
        if (i2c_scl !== level)
        begin
            $display("ERROR at %0t ns: bus clock never reached level %0b", $time, level);
            stop_on_failure();
        end
    endtask

    // Data set in the low phase and sampled in the high phase of a 16-cycle bit
    task automatic bus_bit(input logic b, output logic sampled);
        sda_m <= b;
        wait_cycles(4);
        i2c_scl <= 1'b1;
        wait_scl_level(1'b1);
        wait_cycles(3);
        sampled = i2c_sda;
        wait_cycles(4);
        i2c_scl <= 1'b0;
        wait_scl_level(1'b0);
        wait_cycles(3);
    endtask

    task automatic bus_start();
        sda_m <= 1'b1;
        wait_cycles(4);
        i2c_scl <= 1'b1;
        wait_scl_level(1'b1);
        wait_cycles(7);
        sda_m <= 1'b0;
        wait_cycles(8);
        i2c_scl <= 1'b0;
        wait_scl_level(1'b0);
        wait_cycles(3);
    endtask

    // Leaves both lines high
    task automatic bus_stop();
        sda_m <= 1'b0;
        wait_cycles(4);
        i2c_scl <= 1'b1;
        wait_scl_level(1'b1);
        wait_cycles(7);
        sda_m <= 1'b1;
        wait_cycles(8);
    endtask

    task automatic send_byte(input logic [7:0] data, output logic ack);
        logic s;
        int   i;
        for (i = 7; i >= 0; i--)
        begin
            bus_bit(data[i], s);
        end
        bus_bit(1'b1, s);
        ack = ~s;
    endtask

    task automatic recv_byte(input logic master_ack, output logic [7:0] data);
        logic s;
        int   i;
        for (i = 7; i >= 0; i--)
        begin
            bus_bit(1'b1, s);
            data[i] = s;
        end
        bus_bit(~master_ack, s);
    endtask

    task automatic address_phase(input logic [`EEPROM_AW-1:0] addr);
        logic ack;
        bus_start();
        send_byte({`EEPROM_DEV_CODE, addr[`EEPROM_AW-1:8], 1'b0}, ack);
        check_ack(ack, 1'b1, "write control byte");
        send_byte(addr[7:0], ack);
        check_ack(ack, 1'b1, "address byte");
    endtask

    // Writes wr_q from addr on and mirrors it in ref_mem
    task automatic write_seq(input logic [`EEPROM_AW-1:0] addr);
        logic                  ack;
        logic [`EEPROM_AW-1:0] a;
        int                    i;
        a = addr;
        address_phase(addr);
        for (i = 0; i < wr_q.size(); i++)
        begin
            send_byte(wr_q[i], ack);
            check_ack(ack, 1'b1, "write data byte");
            ref_mem[a] = wr_q[i];
            a = a + 1'b1;
        end
        bus_stop();
    endtask

    // Random read of n bytes ending in a NACK
    task automatic read_and_compare(input logic [`EEPROM_AW-1:0] addr, input int n,
                                    input string what);
        logic                  ack;
        logic [7:0]            data;
        logic [`EEPROM_AW-1:0] a;
        int                    i;
        rd_q.delete();
        address_phase(addr);
        bus_start();
        send_byte({`EEPROM_DEV_CODE, addr[`EEPROM_AW-1:8], 1'b1}, ack);
        check_ack(ack, 1'b1, "read control byte");
        for (i = 0; i < n; i++)
        begin
            recv_byte(i != n - 1, data);
            rd_q.push_back(data);
        end
        bus_stop();
        a = addr;
        for (i = 0; i < n; i++)
        begin
            check_byte(rd_q[i], ref_mem[a], what);
            a = a + 1'b1;
        end
    endtask

    task automatic idle_line_after_reset();
        int i;
        for (i = 0; i < IDLE_CYCLES; i++)
        begin
            @(posedge scl);
            check_oe(i2c_sda_oe, 1'b0, "idle bus after reset");
        end
    endtask

    task automatic single_write_read();
        kept_addr = random_addr();
        wr_q.delete();
        wr_q.push_back(random_byte());
        write_seq(kept_addr);
        read_and_compare(kept_addr, 1, "single byte read back");
    endtask

    task automatic block_independence();
        logic [7:0]            d;
        logic [`EEPROM_AW-1:0] a1;
        logic [`EEPROM_AW-1:0] a2;
        a1 = random_addr();
        d  = random_byte();
        // Same address byte in another block
        a2 = {a1[`EEPROM_AW-1:8] ^ 3'b101, a1[7:0]};
        wr_q.delete();
        wr_q.push_back(d);
        write_seq(a1);
        wr_q.delete();
        wr_q.push_back(~d);
        write_seq(a2);
        read_and_compare(a1, 1, "first block");
        read_and_compare(a2, 1, "second block");
    endtask

    task automatic sequential_wrap();
        int i;
        wr_q.delete();
        for (i = 0; i < 6; i++)
        begin
            wr_q.push_back(random_byte());
        end
        write_seq(11'd2045);
        read_and_compare(11'd2045, 6, "sequential read across the top");
    endtask

    task automatic foreign_device_ignored();
        logic ack;
        bus_start();
        send_byte({`EEPROM_DEV_CODE ^ 4'b0001, kept_addr[`EEPROM_AW-1:8], 1'b0}, ack);
        check_ack(ack, 1'b0, "foreign control byte");
        send_byte(kept_addr[7:0], ack);
        check_ack(ack, 1'b0, "address after foreign control");
        send_byte(~ref_mem[kept_addr], ack);
        check_ack(ack, 1'b0, "data after foreign control");
        bus_stop();
        read_and_compare(kept_addr, 1, "location after foreign device");
    endtask

    task automatic stop_mid_byte();
        logic [7:0] old;
        logic       s;
        int         i;
        old = ref_mem[kept_addr];
        address_phase(kept_addr);
        // Half a data byte, then the stop
        for (i = 7; i >= 4; i--)
        begin
            bus_bit(~old[i], s);
        end
        bus_stop();
        read_and_compare(kept_addr, 1, "location after aborted byte");
        wr_q.delete();
        wr_q.push_back(~old);
        write_seq(kept_addr);
        read_and_compare(kept_addr, 1, "write after aborted byte");
    endtask

    initial
    begin
        rst_n   = 1'b0;
        i2c_scl = 1'b1;
        sda_m   = 1'b1;
        wait_cycles(10);
        rst_n <= 1'b1;
        wait_cycles(2);

        idle_line_after_reset();
        single_write_read();
        block_independence();
        sequential_wrap();
        foreign_device_ignored();
        stop_mid_byte();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
eeprom_pkg.sv
eeprom_ifs.sv
eeprom_line_sampler.sv
eeprom_protocol_fsm.sv
eeprom_storage.sv
eeprom_sda_driver.sv
eeprom_top.sv
tb_eeprom_top.sv

/* Bender.yml */
package:
  name: eeprom_two_wire_slave

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - eeprom_pkg.sv
      - eeprom_ifs.sv
      - eeprom_line_sampler.sv
      - eeprom_protocol_fsm.sv
      - eeprom_storage.sv
      - eeprom_sda_driver.sv
      - eeprom_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_eeprom_top.sv
